/* verilog/ctrl_defines.svh */
/*
 * Opcode values, condition-code bit positions and microcode depth.
 * Only the opcodes listed here are decoded, all others run as NOP.
 */
`ifndef CTRL_DEFINES_SVH
`define CTRL_DEFINES_SVH

// opcodes handled by the controller
`define OP_NOP      8'h12
`define OP_BRA_BASE 8'h20
`define OP_LBRA     8'h16
`define OP_JMP      8'h7E
`define OP_PSHS     8'h34
`define OP_PULS     8'h35
`define OP_LDA      8'h86
`define OP_LDB      8'hC6
`define OP_LDD      8'hCC
`define OP_LDX      8'h8E

// condition-code register bits
`define CC_E 7
`define CC_F 6
`define CC_H 5
`define CC_I 4
`define CC_N 3
`define CC_Z 2
`define CC_V 1
`define CC_C 0

// longest microcode sequence, in steps
`define UCODE_STEPS 4

`endif

/* verilog/ctrl_pkg.sv */
/*
 * Shared types for the instruction controller.
 * Field order inside the packed structs sets the bit layout, MSB first.
 */
`default_nettype none

package ctrl_pkg;

    typedef logic [7:0]  opcode_t;
    typedef logic [7:0]  byte_t;
    typedef logic [15:0] word_t;
    typedef logic [15:0] addr_t;
    typedef logic [7:0]  ccr_t;

    // one microcode step
    typedef struct packed {
        // last step, bumps the PC
        logic ni;
        // operand byte consumed, bumps the PC
        logic opd;
        // conditional 8-bit relative branch
        logic br8;
        // 16-bit relative branch
        logic br16;
        // absolute jump to mdata
        logic jmp;
        logic ld8;
        logic ld16;
        // kick off the stack sequencer
        logic psh_go;
        logic pul_go;
    } uop_t;

    // register write strobes
    typedef struct packed {
        logic a;
        logic b;
        logic d;
        logic x;
        logic y;
        logic u;
        logic s;
    } reg_up_t;

    // one push or pull byte step
    typedef struct packed {
        // postbyte bit being moved, one-hot
        byte_t sel;
        // high byte of a 16-bit register
        logic  hihalf;
        logic  pul_en;
        logic  psh_dec;
    } stack_step_t;

endpackage

`default_nettype wire

/* verilog/ctrl_branch.sv */
/*
 * Branch predicate for the sixteen short branches.
 * Purely combinational, the low opcode nibble picks the test.
 */
`timescale 1ns/1ps
`default_nettype none
`include "ctrl_defines.svh"

module ctrl_branch import ctrl_pkg::*; (
    input  opcode_t op,
    input  ccr_t    cc,
    output logic    branch_ok
);

    logic n, z, v, c;

    assign n = cc[`CC_N];
    assign z = cc[`CC_Z];
    assign v = cc[`CC_V];
    assign c = cc[`CC_C];

    always_comb begin
        case (op[3:0])
            4'h0: branch_ok = 1'b1;              // BRA
            4'h1: branch_ok = 1'b0;              // BRN
            4'h2: branch_ok = ~(c | z);          // BHI
            4'h3: branch_ok = c | z;             // BLS
            4'h4: branch_ok = ~c;                // BCC
            4'h5: branch_ok = c;                 // BCS
            4'h6: branch_ok = ~z;                // BNE
            4'h7: branch_ok = z;                 // BEQ
            4'h8: branch_ok = ~v;                // BVC
            4'h9: branch_ok = v;                 // BVS
            4'hA: branch_ok = ~n;                // BPL
            4'hB: branch_ok = n;                 // BMI
            // signed compares
            4'hC: branch_ok = ~(n ^ v);
            4'hD: branch_ok = n ^ v;
            4'hE: branch_ok = ~(z | (n ^ v));
            default: branch_ok = z | (n ^ v);
        endcase
    end

endmodule

`default_nettype wire

/* verilog/ctrl_stack_seq.sv */
/*
 * Push and pull step sequencer, one byte step per enabled clock.
 * The postbyte mask is taken from mdata[7:0] on the go strobe.
 * Bits 7..4 name 16-bit registers and take two steps each.
 */
`timescale 1ns/1ps
`default_nettype none

module ctrl_stack_seq import ctrl_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        cen,
    input  logic        psh_go,
    input  logic        pul_go,
    input  word_t       mdata,
    output stack_step_t stk,
    output logic        busy
);

    byte_t rem;
    logic  pull;
    logic  half;
    byte_t pick;
    byte_t rem_next;
    logic  wide;

    // push takes the highest set bit first, pull the lowest
    function automatic byte_t first_bit(byte_t m, logic from_low);
        byte_t r;
        r = '0;
        if (from_low) begin
            for (int i = 7; i >= 0; i--) begin
                if (m[i]) begin
                    r = byte_t'(1) << i;
                end
            end
        end else begin
            for (int i = 0; i < 8; i++) begin
                if (m[i]) begin
                    r = byte_t'(1) << i;
                end
            end
        end
        return r;
    endfunction

    assign pick     = first_bit(rem, pull);
    assign rem_next = rem & ~pick;
    assign wide     = |pick[7:4];

    assign stk.sel     = busy ? pick : '0;
    assign stk.hihalf  = busy & half;
    assign stk.pul_en  = busy & pull;
    assign stk.psh_dec = busy & ~pull;

    always_ff @(posedge clk) begin
        if (rst) begin
            rem  <= '0;
            pull <= 1'b0;
            half <= 1'b0;
            busy <= 1'b0;
        end else if (cen) begin
            if (psh_go || pul_go) begin
                rem  <= mdata[7:0];
                pull <= pul_go;
                // push starts on the low byte, pull on the high byte
                half <= pul_go;
                busy <= |mdata[7:0];
            end else if (busy) begin
                if (wide && (half == pull)) begin
                    half <= ~half;
                end else begin
                    rem  <= rem_next;
                    half <= pull;
                    busy <= |rem_next;
                end
            end
        end
    end

    a_sel_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(stk.sel));

    // the microcode must hold off new stack work until this one drains
    a_no_go_busy: assert property (@(posedge clk) disable iff (rst)
        busy |-> !(psh_go || pul_go));

endmodule

`default_nettype wire

/* verilog/ctrl_ucode.sv */
/*
 * Microcode table and step sequencer.
 * op must stay stable until the step carrying ni has been taken.
 * Any stall zeroes the whole microinstruction and freezes the step.
 */
`timescale 1ns/1ps
`default_nettype none
`include "ctrl_defines.svh"

module ctrl_ucode import ctrl_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    cen,
    input  opcode_t op,
    input  logic    mem_busy,
    input  logic    stack_busy,
    output uop_t    uop
);

    localparam int STEP_W = $clog2(`UCODE_STEPS);

    typedef logic [STEP_W-1:0] step_t;

    typedef enum logic [2:0] {
        CL_NOP,
        CL_BCC,
        CL_LBRA,
        CL_JMP,
        CL_LD8,
        CL_LD16,
        CL_STK
    } op_class_t;

    op_class_t cls;
    step_t     step;
    uop_t      raw;
    logic      stall;

    // table lookup by class and step, unused slots end the instruction
    function automatic uop_t ucode_entry(op_class_t cl, step_t st, logic pull);
        uop_t u;
        u = '0;
        case (cl)
            CL_BCC: begin
                case (st)
                    2'd0:    u.opd = 1'b1;
                    2'd1:    u.br8 = 1'b1;
                    default: u.ni  = 1'b1;
                endcase
            end
            CL_LBRA: begin
                case (st)
                    2'd0, 2'd1: u.opd  = 1'b1;
                    2'd2:       u.br16 = 1'b1;
                    default:    u.ni   = 1'b1;
                endcase
            end
            CL_JMP: begin
                case (st)
                    2'd0, 2'd1: u.opd = 1'b1;
                    2'd2:       u.jmp = 1'b1;
                    default:    u.ni  = 1'b1;
                endcase
            end
            CL_LD8: begin
                if (st == 2'd0) begin
                    u.opd = 1'b1;
                    u.ld8 = 1'b1;
                end else begin
                    u.ni = 1'b1;
                end
            end
            CL_LD16: begin
                case (st)
                    2'd0: u.opd = 1'b1;
                    2'd1: begin
                        u.opd  = 1'b1;
                        u.ld16 = 1'b1;
                    end
                    default: u.ni = 1'b1;
                endcase
            end
            CL_STK: begin
                case (st)
                    2'd0:    u.opd = 1'b1;
                    2'd1: begin
                        u.psh_go = ~pull;
                        u.pul_go = pull;
                    end
                    default: u.ni = 1'b1;
                endcase
            end
            default: u.ni = 1'b1;
        endcase
        return u;
    endfunction

    always_comb begin
        case (op)
            `OP_NOP:  cls = CL_NOP;
            `OP_LBRA: cls = CL_LBRA;
            `OP_JMP:  cls = CL_JMP;
            `OP_LDA,
            `OP_LDB:  cls = CL_LD8;
            `OP_LDD,
            `OP_LDX:  cls = CL_LD16;
            `OP_PSHS,
            `OP_PULS: cls = CL_STK;
            default: begin
                // 20h..2Fh are the short branches
                if ((op & 8'hF0) == `OP_BRA_BASE) begin
                    cls = CL_BCC;
                end else begin
                    cls = CL_NOP;
                end
            end
        endcase
    end

    assign raw   = ucode_entry(cls, step, op == `OP_PULS);
    assign stall = mem_busy | stack_busy;
    assign uop   = stall ? uop_t'('0) : raw;

    always_ff @(posedge clk) begin
        if (rst) begin
            step <= '0;
        end else if (cen && !stall) begin
            if (raw.ni) begin
                step <= '0;
            end else begin
                step <= step_t'(step + 1'b1);
            end
        end
    end

    // op is held by the outside while an instruction is in flight
    a_op_held: assert property (@(posedge clk) disable iff (rst)
        (step != '0) |-> $stable(op));

    a_no_uop_in_stall: assert property (@(posedge clk) disable iff (rst)
        (mem_busy || stack_busy) |-> (uop == '0));

endmodule

`default_nettype wire

/* verilog/cpu_ctrl.sv */
/*
 * Instruction controller top: PC, register strobes and sub-blocks.
 * State moves only on clk edges with cen high.
 * mem_busy stalls the microcode and freezes the PC.
 */
`timescale 1ns/1ps
`default_nettype none
`include "ctrl_defines.svh"

module cpu_ctrl import ctrl_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        cen,
    input  opcode_t     op,
    input  word_t       mdata,
    input  ccr_t        cc,
    input  logic        mem_busy,
    output addr_t       pc,
    output uop_t        uop,
    output reg_up_t     reg_up,
    output stack_step_t stk
);

    logic  branch_ok;
    logic  stack_busy;
    addr_t br_off;

    ctrl_ucode u_ucode (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .cen        ( cen        ),
        .op         ( op         ),
        .mem_busy   ( mem_busy   ),
        .stack_busy ( stack_busy ),
        .uop        ( uop        )
    );

    ctrl_branch u_branch (
        .op        ( op        ),
        .cc        ( cc        ),
        .branch_ok ( branch_ok )
    );

    ctrl_stack_seq u_stack (
        .clk    ( clk        ),
        .rst    ( rst        ),
        .cen    ( cen        ),
        .psh_go ( uop.psh_go ),
        .pul_go ( uop.pul_go ),
        .mdata  ( mdata      ),
        .stk    ( stk        ),
        .busy   ( stack_busy )
    );

    // sign-extended short branch offset
    assign br_off = {{8{mdata[7]}}, mdata[7:0]};

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (cen) begin
            if (uop.ni || uop.opd) begin
                pc <= pc + 16'd1;
            end else if (uop.br8 && branch_ok) begin
                pc <= pc + br_off;
            end else if (uop.br16) begin
                pc <= pc + mdata;
            end else if (uop.jmp) begin
                pc <= mdata;
            end
        end
    end

    // load strobes, uop is already zero while stalled
    always_comb begin
        reg_up   = '0;
        reg_up.a = uop.ld8 && (op == `OP_LDA);
        reg_up.b = uop.ld8 && (op == `OP_LDB);
        reg_up.d = uop.ld16 && (op == `OP_LDD);
        reg_up.x = uop.ld16 && (op == `OP_LDX);
        // no supported opcode writes y, u or s
        reg_up.y = 1'b0;
        reg_up.u = 1'b0;
        reg_up.s = 1'b0;
    end

    a_pc_cen_hold: assert property (@(posedge clk) disable iff (rst)
        !cen |=> $stable(pc));

endmodule

`default_nettype wire

/* verification/tb_cpu_ctrl.sv */
/*
 * Testbench for the instruction controller top level.
 * op, mdata and cc are held for a whole instruction, inputs change on the falling edge.
 * Narrow stack steps are compared without hihalf, which is only defined for 16-bit registers.
 */
`timescale 1ns/1ps
`default_nettype none
`include "ctrl_defines.svh"

module tb_cpu_ctrl import ctrl_pkg::*; ();

    logic        clk;
    logic        rst;
    logic        cen;
    opcode_t     op;
    word_t       mdata;
    ccr_t        cc;
    logic        mem_busy;
    addr_t       pc;
    uop_t        uop;
    reg_up_t     reg_up;
    stack_step_t stk;

    logic [31:0] rng;
    logic        stall_mode;
    logic        end_chk;
    logic        post_rst_chk;
    addr_t       exp_pc;
    reg_up_t     exp_up;
    reg_up_t     up_seen;
    logic        up_twice;
    stack_step_t exp_stk;
    stack_step_t stk_q[$];
    int          stk_idx;
    int          stk_cnt;
    logic        stk_on;
    stack_step_t stk_cmp;

    cpu_ctrl dut0 (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .cen      ( cen      ),
        .op       ( op       ),
        .mdata    ( mdata    ),
        .cc       ( cc       ),
        .mem_busy ( mem_busy ),
        .pc       ( pc       ),
        .uop      ( uop      ),
        .reg_up   ( reg_up   ),
        .stk      ( stk      )
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    assign stk_on  = (stk.sel != '0) || stk.pul_en || stk.psh_dec;
    // hihalf only counts on bits 7..4
    assign stk_cmp = {stk.sel, stk.hihalf & (|stk.sel[7:4]), stk.pul_en, stk.psh_dec};

    task automatic fail_stop();
        $display("TEST FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic show_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] expv);
        $display("CHECK FAILED %s got %h expected %h", name, got, expv);
        fail_stop();
    endtask

    task automatic give_up(input string why);
        $display("ERROR %s", why);
        fail_stop();
    endtask

    function automatic logic [31:0] rand_next();
        rng = rng * 32'd1103515245 + 32'd12345;
        return {rng[15:0], rng[31:16]};
    endfunction

    // odd conditions are the negation of the even one below them
    function automatic logic branch_taken(input logic [3:0] cond, input ccr_t f);
        logic n;
        logic z;
        logic v;
        logic c;
        logic t;
        n = f[`CC_N];
        z = f[`CC_Z];
        v = f[`CC_V];
        c = f[`CC_C];
        case (cond[3:1])
            3'd0:    t = 1'b1;
            3'd1:    t = ~(c | z);
            3'd2:    t = ~c;
            3'd3:    t = ~z;
            3'd4:    t = ~v;
            3'd5:    t = ~n;
            3'd6:    t = ~(n ^ v);
            default: t = ~(z | (n ^ v));
        endcase
        return cond[0] ? ~t : t;
    endfunction

    // push goes from bit 7 down, pull from bit 0 up
    task automatic build_stack_order(input byte_t mask, input logic pull);
        stack_step_t e;
        int b;
        stk_q.delete();
        for (int i = 0; i < 8; i++) begin
            b = pull ? i : 7 - i;
            if (mask[b]) begin
                e.sel     = byte_t'(1) << b;
                e.pul_en  = pull;
                e.psh_dec = ~pull;
                if (b >= 4) begin
                    e.hihalf = pull;
                    stk_q.push_back(e);
                    e.hihalf = ~pull;
                    stk_q.push_back(e);
                end else begin
                    e.hihalf = 1'b0;
                    stk_q.push_back(e);
                end
            end
        end
    endtask

    task automatic drive_ctrl();
        logic [31:0] r;
        if (stall_mode) begin
            r        = rand_next();
            cen      = (r[1:0] != 2'd0);
            mem_busy = (r[3:2] == 2'd0);
        end else begin
            cen      = 1'b1;
            mem_busy = 1'b0;
        end
    endtask

    // entered on a falling edge, returns on a falling edge
    task automatic run_instr(input opcode_t o, input word_t d, input addr_t next_pc,
                             input reg_up_t up);
        logic done;
        int cycles;
        op       = o;
        mdata    = d;
        up_seen  = '0;
        up_twice = 1'b0;
        stk_idx  = 0;
        stk_cnt  = stk_q.size();
        done     = 1'b0;
        cycles   = 0;
        while (!done) begin
            drive_ctrl();
            #1;
            if (cen) begin
                done = uop.ni;
                if ((up_seen & reg_up) != '0) begin
                    up_twice = 1'b1;
                end
                up_seen = up_seen | reg_up;
                if (stk_on) begin
                    exp_stk = (stk_idx < stk_cnt) ? stk_q[stk_idx] : '0;
                    stk_idx++;
                end
            end
            @(negedge clk);
            cycles++;
            if (!done && cycles >= 200) begin
                give_up($sformatf("no ni within 200 cycles for opcode %h", o));
            end
        end
        exp_pc   = next_pc;
        exp_up   = up;
        cen      = 1'b0;
        mem_busy = 1'b0;
        end_chk  = 1'b1;
        @(negedge clk);
        end_chk  = 1'b0;
        stk_q.delete();
    endtask

    a_post_rst_pc: assert property (@(posedge clk) post_rst_chk |-> (pc == '0))
        else show_mismatch("pc", $sampled(pc), 32'h0);

    a_post_rst_quiet: assert property (@(posedge clk)
        post_rst_chk |-> (uop == '0 && reg_up == '0 && stk == '0))
        else show_mismatch("uop,reg_up,stk",
                           32'({$sampled(uop), $sampled(reg_up), $sampled(stk)}), 32'h0);

    a_end_pc: assert property (@(posedge clk) end_chk |-> (pc == exp_pc))
        else show_mismatch("pc", $sampled(pc), $sampled(exp_pc));

    a_end_up: assert property (@(posedge clk) end_chk |-> (up_seen == exp_up))
        else show_mismatch("reg_up", $sampled(up_seen), $sampled(exp_up));

    a_up_once: assert property (@(posedge clk) end_chk |-> !up_twice)
        else give_up("a reg_up strobe pulsed more than once in one instruction");

    a_stk_count: assert property (@(posedge clk) end_chk |-> (stk_idx == stk_cnt))
        else show_mismatch("stack step count", $sampled(stk_idx), $sampled(stk_cnt));

    a_stk_order: assert property (@(posedge clk) disable iff (rst)
        (cen && stk_on) |-> (stk_cmp == exp_stk))
        else show_mismatch("stk", $sampled(stk_cmp), $sampled(exp_stk));

    a_stall_quiet: assert property (@(posedge clk) disable iff (rst)
        mem_busy |-> (uop == '0))
        else show_mismatch("uop", $sampled(uop), 32'h0);

    a_pc_hold: assert property (@(posedge clk) disable iff (rst)
        !cen |=> $stable(pc))
        else show_mismatch("pc", $sampled(pc), $past(pc));

    initial begin
        reg_up_t up;
        word_t   d;
        byte_t   mask;
        addr_t   target;
        rng          = 32'd90070;
        rst          = 1'b1;
        cen          = 1'b0;
        op           = `OP_NOP;
        mdata        = '0;
        cc           = '0;
        mem_busy     = 1'b1;
        stall_mode   = 1'b0;
        end_chk      = 1'b0;
        post_rst_chk = 1'b0;
        exp_pc       = '0;
        exp_up       = '0;
        up_seen      = '0;
        up_twice     = 1'b0;
        exp_stk      = '0;
        stk_idx      = 0;
        stk_cnt      = 0;
        repeat (4) @(negedge clk);
        rst          = 1'b0;
        cen          = 1'b1;
        // mem_busy stays high so the microcode shows nothing yet
        post_rst_chk = 1'b1;
        repeat (2) @(negedge clk);
        post_rst_chk = 1'b0;

        // second pass repeats everything with random stalls
        for (int pass = 0; pass < 2; pass++) begin
            stall_mode = pass[0];
            run_instr(`OP_NOP, word_t'(rand_next()), exp_pc + 16'd1, '0);
            up = '0;
            up.a = 1'b1;
            run_instr(`OP_LDA, word_t'(rand_next()), exp_pc + 16'd2, up);
            up = '0;
            up.b = 1'b1;
            run_instr(`OP_LDB, word_t'(rand_next()), exp_pc + 16'd2, up);
            up = '0;
            up.d = 1'b1;
            run_instr(`OP_LDD, word_t'(rand_next()), exp_pc + 16'd3, up);
            up = '0;
            up.x = 1'b1;
            run_instr(`OP_LDX, word_t'(rand_next()), exp_pc + 16'd3, up);
            for (int k = 0; k < 16; k++) begin
                d      = word_t'(rand_next());
                cc     = ccr_t'(rand_next());
                target = exp_pc + 16'd2;
                if (branch_taken(k[3:0], cc)) begin
                    target = target + {{8{d[7]}}, d[7:0]};
                end
                run_instr(`OP_BRA_BASE | opcode_t'(k), d, target, '0);
            end
            d = word_t'(rand_next());
            run_instr(`OP_LBRA, d, exp_pc + 16'd3 + d, '0);
            d = word_t'(rand_next());
            run_instr(`OP_JMP, d, d + 16'd1, '0);
            for (int k = 0; k < 4; k++) begin
                mask = (k == 0) ? 8'h00 : (k == 1) ? 8'hFF : byte_t'(rand_next());
                build_stack_order(mask, 1'b0);
                run_instr(`OP_PSHS, {byte_t'(rand_next()), mask}, exp_pc + 16'd2, '0);
                mask = byte_t'(rand_next());
                build_stack_order(mask, 1'b1);
                run_instr(`OP_PULS, {byte_t'(rand_next()), mask}, exp_pc + 16'd2, '0);
            end
        end
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+verilog
verilog/ctrl_pkg.sv
verilog/ctrl_branch.sv
verilog/ctrl_stack_seq.sv
verilog/ctrl_ucode.sv
verilog/cpu_ctrl.sv
verification/tb_cpu_ctrl.sv
